// ==== tb.f ====
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/bus_arbiter.sv
rtl/address_decoder.sv
rtl/block_ram.sv
rtl/control_registers.sv
rtl/soc_fabric.sv
sim/tb_clock_gen.sv
sim/tb_soc_fabric.sv

// ==== sim/tb_soc_fabric.sv ====
`timescale 1ns/100ps

module tb_soc_fabric import soc_bus_pkg::*, soc_map_pkg::*; ();

	localparam int RAM_WORDS       = 1024;
	localparam int RAM_LATENCY     = 3;
	localparam int TIMER_PRESCALE  = 4;
	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = 200;
	localparam int ACCESS_LIMIT    = 50;
	localparam int RAM_CHECKS      = 8;

	logic     clock;
	logic     reset;
	bus_req_t instr_req;
	bus_req_t data_req;
	bus_req_t dma_req;
	bus_rsp_t instr_rsp;
	bus_rsp_t data_rsp;
	bus_rsp_t dma_rsp;
	led_t     leds;
	logic     timer_interrupt;
	logic     bus_fault;

	integer   seed;
	int       errors;
	string    test_name;
	data_t    ram_model [RAM_WORDS];

	tb_clock_gen clock_gen (
		.o_clock (clock),
		.o_reset (reset)
	);

	soc_fabric #(
		.RAM_WORDS      (RAM_WORDS),
		.RAM_LATENCY    (RAM_LATENCY),
		.TIMER_PRESCALE (TIMER_PRESCALE)
	) DUT (
		.clock             (clock),
		.i_reset           (reset),
		.i_instr_req       (instr_req),
		.i_data_req        (data_req),
		.i_dma_req         (dma_req),
		.o_instr_rsp       (instr_rsp),
		.o_data_rsp        (data_rsp),
		.o_dma_rsp         (dma_rsp),
		.o_leds            (leds),
		.o_timer_interrupt (timer_interrupt),
		.o_bus_fault       (bus_fault)
	);

	//============================================================
	// Bus access helpers
	//============================================================

	function automatic string port_label(input grant_t port);
		case (port)
			GRANT_DATA:  return "data";
			GRANT_DMA:   return "DMA";
			GRANT_INSTR: return "instruction";
			default:     return "none";
		endcase
	endfunction

	// Word slot inside the RAM, upper bits wrap
	function automatic int ram_word(input addr_t address);
		return (address >> 2) % RAM_WORDS;
	endfunction

	task automatic drive_port(input grant_t port, input bus_req_t req);
		case (port)
			GRANT_DATA:  data_req <= req;
			GRANT_DMA:   dma_req <= req;
			GRANT_INSTR: instr_req <= req;
			default: ;
		endcase
	endtask

	function automatic bus_rsp_t port_response(input grant_t port);
		case (port)
			GRANT_DATA:  return data_rsp;
			GRANT_DMA:   return dma_rsp;
			GRANT_INSTR: return instr_rsp;
			default:     return '0;
		endcase
	endfunction

	// One transaction, cycles is the ready cycle counted from the request cycle
	task automatic bus_access(
		input  grant_t port,
		input  logic   rw,
		input  addr_t  address,
		input  data_t  wdata,
		output data_t  rdata,
		output logic   fault,
		output int     cycles
	);
		bus_req_t req;
		bus_rsp_t rsp;
		int       waited;
		logic     seen;
		req.request = 1'b1;
		req.rw      = rw;
		req.address = address;
		req.wdata   = wdata;
		waited      = 0;
		seen        = 1'b0;
		rdata       = '0;
		fault       = 1'b0;
		@(posedge clock);
		drive_port(port, req);
		while (!seen && waited < ACCESS_LIMIT) begin
			@(posedge clock);
			waited++;
			rsp = port_response(port);
			if (rsp.ready) begin
				seen  = 1'b1;
				rdata = rsp.rdata;
				fault = bus_fault;
			end
		end
		drive_port(port, '0);
		cycles = waited - 1;
		if (!seen) begin
			errors++;
			$display("Error in %s: no ready on the %s port after %0d cycles",
				test_name, port_label(port), ACCESS_LIMIT);
		end
	endtask

	//============================================================
	// Compare tasks
	//============================================================

	task automatic compare_data(input string what, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			errors++;
			$display("Error in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic compare_leds(input string what, input led_t expected, input led_t actual);
		if (actual !== expected) begin
			errors++;
			$display("Error in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic compare_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("Error in %s, %s: expected %b, actual %b", test_name, what, expected, actual);
		end
	endtask

	//============================================================
	// Directed tests
	//============================================================

	task automatic test_ram_access();
		addr_t addrs [RAM_CHECKS];
		data_t wdata;
		data_t rdata;
		logic  fault;
		int    cycles;
		int    word;
		grant_t port;
		test_name = "ram_access";
		for (int i = 0; i < RAM_CHECKS; i++) begin
			word     = $random(seed);
			addrs[i] = {REGION_RAM, 16'd0, 10'(word), 2'b00};
			wdata    = $random(seed);
			bus_access(GRANT_DATA, 1'b1, addrs[i], wdata, rdata, fault, cycles);
			ram_model[ram_word(addrs[i])] = wdata;
		end
		// Overwrite one word so the read must see the later value
		wdata = $random(seed);
		bus_access(GRANT_DATA, 1'b1, addrs[0], wdata, rdata, fault, cycles);
		ram_model[ram_word(addrs[0])] = wdata;
		for (int i = 0; i < RAM_CHECKS; i++) begin
			for (int p = 1; p <= 3; p++) begin
				port = grant_t'(p);
				bus_access(port, 1'b0, addrs[i], '0, rdata, fault, cycles);
				compare_data({"read on ", port_label(port), " port"},
					ram_model[ram_word(addrs[i])], rdata);
			end
		end
	endtask

	task automatic test_led_register();
		data_t wdata;
		data_t rdata;
		logic  fault;
		int    cycles;
		test_name = "led_register";
		for (int i = 0; i < 3; i++) begin
			wdata = $random(seed);
			bus_access(GRANT_DATA, 1'b1, 32'h4000_0000, wdata, rdata, fault, cycles);
			@(posedge clock);
			compare_leds("LED output", wdata[9:0], leds);
			bus_access(GRANT_DATA, 1'b0, 32'h4000_0000, '0, rdata, fault, cycles);
			compare_data("LED readback", {22'd0, wdata[9:0]}, rdata);
		end
	endtask

	task automatic test_arbitration();
		addr_t addr_a;
		addr_t addr_b;
		data_t rdata_a;
		data_t rdata_b;
		data_t scratch;
		logic  fault_a;
		logic  fault_b;
		int    cycles_a;
		int    cycles_b;
		test_name = "arbitration";
		addr_a = 32'h1000_0100;
		addr_b = 32'h1000_0204;
		ram_model[ram_word(addr_a)] = $random(seed);
		ram_model[ram_word(addr_b)] = $random(seed);
		bus_access(GRANT_DATA, 1'b1, addr_a, ram_model[ram_word(addr_a)],
			scratch, fault_a, cycles_a);
		bus_access(GRANT_DATA, 1'b1, addr_b, ram_model[ram_word(addr_b)],
			scratch, fault_a, cycles_a);
		// Both masters raise request on the same edge
		fork
			bus_access(GRANT_DATA, 1'b0, addr_a, '0, rdata_a, fault_a, cycles_a);
			bus_access(GRANT_INSTR, 1'b0, addr_b, '0, rdata_b, fault_b, cycles_b);
		join
		compare_bit("data port served first", 1'b1, cycles_a < cycles_b);
		compare_data("data port read", ram_model[ram_word(addr_a)], rdata_a);
		compare_data("instruction port read", ram_model[ram_word(addr_b)], rdata_b);
	endtask

	task automatic test_timer();
		data_t rdata;
		data_t first;
		logic  fault;
		logic  seen;
		int    cycles;
		int    waited;
		test_name = "timer";
		bus_access(GRANT_DATA, 1'b1, 32'ha000_0004, 32'd5, rdata, fault, cycles);
		bus_access(GRANT_DATA, 1'b1, 32'ha000_0000, 32'd0, rdata, fault, cycles);
		bus_access(GRANT_DATA, 1'b1, 32'ha000_0008, 32'd1, rdata, fault, cycles);
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < 5 * TIMER_PRESCALE + 10) begin
			@(posedge clock);
			waited++;
			seen = timer_interrupt;
		end
		compare_bit("interrupt raised in time", 1'b1, seen);
		bus_access(GRANT_DATA, 1'b0, 32'ha000_0008, '0, rdata, fault, cycles);
		compare_bit("pending bit", 1'b1, rdata[1]);
		// Clear pending, timer stays enabled
		bus_access(GRANT_DATA, 1'b1, 32'ha000_0008, 32'd1, rdata, fault, cycles);
		@(posedge clock);
		compare_bit("interrupt after clear", 1'b0, timer_interrupt);
		bus_access(GRANT_DATA, 1'b0, 32'ha000_0000, '0, first, fault, cycles);
		bus_access(GRANT_DATA, 1'b0, 32'ha000_0000, '0, rdata, fault, cycles);
		compare_bit("count non-decreasing", 1'b1, rdata >= first);
	endtask

	task automatic test_unmapped_access();
		data_t rdata;
		logic  fault;
		int    cycles;
		test_name = "unmapped_access";
		bus_access(GRANT_DATA, 1'b0, 32'hc000_0010, '0, rdata, fault, cycles);
		compare_data("unmapped rdata", '0, rdata);
		compare_bit("fault with ready", 1'b1, fault);
		@(posedge clock);
		compare_bit("fault pulse width", 1'b0, bus_fault);
	endtask

	//============================================================
	// Sequence and watchdog
	//============================================================

	initial begin
		seed      = 32'h7fcbbf1a;
		errors    = 0;
		test_name = "reset";
		instr_req = '0;
		data_req  = '0;
		dma_req   = '0;
		wait (reset == 1'b0);
		test_ram_access();
		test_led_register();
		test_arbitration();
		test_timer();
		test_unmapped_access();
		repeat (2) @(posedge clock);
		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clock);
		$display("Watchdog expired during %s with %0d errors so far", test_name, errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);

	// 20 ns period
	initial begin
		o_clock = 1'b0;
		forever #10 o_clock = ~o_clock;
	end

	// Reset held for the first 4 rising edges
	initial begin
		o_reset = 1'b1;
		repeat (4) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

// ==== rtl/soc_fabric.sv ====
`timescale 1ns/100ps

module soc_fabric import soc_bus_pkg::*, soc_map_pkg::*; #(
	parameter int RAM_WORDS      = 1024,
	parameter int RAM_LATENCY    = 3,
	parameter int TIMER_PRESCALE = 4
) (
	input  logic     clock,
	input  logic     i_reset,

	input  bus_req_t i_instr_req,
	input  bus_req_t i_data_req,
	input  bus_req_t i_dma_req,
	output bus_rsp_t o_instr_rsp,
	output bus_rsp_t o_data_rsp,
	output bus_rsp_t o_dma_rsp,

	output led_t     o_leds,
	output logic     o_timer_interrupt,
	output logic     o_bus_fault
);

	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t ctrl_req;
	bus_rsp_t ctrl_rsp;
	logic     ctrl_led_select;

	//============================================================
	// Shared bus
	//============================================================

	bus_arbiter arbiter (
		.clock       (clock),
		.i_reset     (i_reset),
		.i_instr_req (i_instr_req),
		.i_data_req  (i_data_req),
		.i_dma_req   (i_dma_req),
		.o_instr_rsp (o_instr_rsp),
		.o_data_rsp  (o_data_rsp),
		.o_dma_rsp   (o_dma_rsp),
		.o_bus_req   (bus_req),
		.i_bus_rsp   (bus_rsp)
	);

	address_decoder decoder (
		.clock             (clock),
		.i_reset           (i_reset),
		.i_bus_req         (bus_req),
		.o_bus_rsp         (bus_rsp),
		.o_ram_req         (ram_req),
		.o_ctrl_req        (ctrl_req),
		.i_ram_rsp         (ram_rsp),
		.i_ctrl_rsp        (ctrl_rsp),
		.o_ctrl_led_select (ctrl_led_select),
		.o_bus_fault       (o_bus_fault)
	);

	//============================================================
	// Slaves
	//============================================================

	block_ram #(
		.WORDS   (RAM_WORDS),
		.LATENCY (RAM_LATENCY)
	) ram (
		.clock   (clock),
		.i_reset (i_reset),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	control_registers #(
		.PRESCALE (TIMER_PRESCALE)
	) ctrl (
		.clock             (clock),
		.i_reset           (i_reset),
		.i_req             (ctrl_req),
		.i_led_select      (ctrl_led_select),
		.o_rsp             (ctrl_rsp),
		.o_leds            (o_leds),
		.o_timer_interrupt (o_timer_interrupt)
	);

endmodule

// ==== rtl/control_registers.sv ====
`timescale 1ns/100ps

module control_registers import soc_bus_pkg::*, soc_map_pkg::*; #(
	parameter int PRESCALE = 4
) (
	input  logic     clock,
	input  logic     i_reset,
	input  bus_req_t i_req,
	input  logic     i_led_select,
	output bus_rsp_t o_rsp,
	output led_t     o_leds,
	output logic     o_timer_interrupt
);

	localparam int PS_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
	localparam logic [PS_W-1:0] PS_LAST = PS_W'(PRESCALE - 1);

	reg_index_t      index;
	logic            access;
	logic            ready;
	data_t           rdata;
	data_t           read_value;
	led_t            leds;
	data_t           count;
	data_t           count_next;
	data_t           compare;
	logic            enable;
	logic            pending;
	logic [PS_W-1:0] prescale_count;

	assign index      = reg_index_t'(i_req.address[3:2]);
	assign access     = i_req.request && !ready;
	assign count_next = count + 1'b1;

	always_comb begin
		if (i_led_select) begin
			read_value = data_t'(leds);
		end else begin
			case (index)
				REG_COUNT:   read_value = count;
				REG_COMPARE: read_value = compare;
				REG_CONTROL: read_value = {30'd0, pending, enable};
				default:     read_value = '0;
			endcase
		end
	end

	//============================================================
	// Timer and register writes
	//============================================================

	always_ff @(posedge clock) begin
		if (i_reset) begin
			ready          <= 1'b0;
			leds           <= '0;
			count          <= '0;
			compare        <= '0;
			enable         <= 1'b0;
			pending        <= 1'b0;
			prescale_count <= '0;
		end else begin
			ready <= access;

			if (enable) begin
				if (prescale_count == PS_LAST) begin
					prescale_count <= '0;
					count          <= count_next;
					// Interrupt on reaching compare
					if (count_next == compare)
						pending <= 1'b1;
				end else begin
					prescale_count <= prescale_count + 1'b1;
				end
			end else begin
				prescale_count <= '0;
			end

			// Bus writes take precedence over the timer
			if (access && i_req.rw) begin
				if (i_led_select) begin
					leds <= i_req.wdata[9:0];
				end else begin
					case (index)
						REG_COUNT:   count <= i_req.wdata;
						REG_COMPARE: compare <= i_req.wdata;
						REG_CONTROL: begin
							enable  <= i_req.wdata[0];
							pending <= 1'b0;
						end
						default: ;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (access)
			rdata <= read_value;
	end

	assign o_rsp             = '{rdata: rdata, ready: ready};
	assign o_leds            = leds;
	assign o_timer_interrupt = pending;

endmodule

// ==== rtl/block_ram.sv ====
`timescale 1ns/100ps

module block_ram import soc_bus_pkg::*; #(
	parameter int WORDS   = 1024,
	parameter int LATENCY = 3
) (
	input  logic     clock,
	input  logic     i_reset,
	input  bus_req_t i_req,
	output bus_rsp_t o_rsp
);

	localparam int INDEX_W = $clog2(WORDS);
	localparam int CNT_W   = $clog2(LATENCY + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(LATENCY - 1);

	data_t mem [WORDS];

	logic [INDEX_W-1:0] index;
	logic [CNT_W-1:0]   count;
	logic               ready;
	logic               done;
	data_t              rdata;

	// Word index, upper address bits fall away
	assign index = i_req.address[INDEX_W+1:2];

	// Last wait cycle of an access still in flight
	assign done = i_req.request && !ready && (count == LAST);

	// Latency counter, the ready cycle itself does not restart it
	always_ff @(posedge clock) begin
		if (i_reset) begin
			count <= '0;
			ready <= 1'b0;
		end else begin
			ready <= done;
			if (i_req.request && !ready && !done)
				count <= count + 1'b1;
			else
				count <= '0;
		end
	end

	// Memory access at the end of the wait
	always_ff @(posedge clock) begin
		if (done) begin
			if (i_req.rw)
				mem[index] <= i_req.wdata;
			rdata <= mem[index];
		end
	end

	assign o_rsp = '{rdata: rdata, ready: ready};

endmodule

// ==== rtl/address_decoder.sv ====
`timescale 1ns/100ps

module address_decoder import soc_bus_pkg::*, soc_map_pkg::*; (
	input  logic     clock,
	input  logic     i_reset,

	input  bus_req_t i_bus_req,
	output bus_rsp_t o_bus_rsp,

	// Slave side
	output bus_req_t o_ram_req,
	output bus_req_t o_ctrl_req,
	input  bus_rsp_t i_ram_rsp,
	input  bus_rsp_t i_ctrl_rsp,
	output logic     o_ctrl_led_select,

	output logic     o_bus_fault
);

	region_t region;
	logic    ram_hit;
	logic    ctrl_hit;
	logic    unmapped;
	logic    fault_pulse;

	assign region   = region_t'(i_bus_req.address[31:28]);
	assign ram_hit  = (region == REGION_RAM);
	assign ctrl_hit = (region == REGION_LED) || (region == REGION_TIMER);
	assign unmapped = !ram_hit && !ctrl_hit;

	assign o_ctrl_led_select = (region == REGION_LED);

	// Per-slave request gating
	always_comb begin
		o_ram_req          = i_bus_req;
		o_ram_req.request  = i_bus_req.request && ram_hit;
		o_ctrl_req         = i_bus_req;
		o_ctrl_req.request = i_bus_req.request && ctrl_hit;
	end

	// Unmapped access completes by itself one cycle later
	always_ff @(posedge clock) begin
		if (i_reset)
			fault_pulse <= 1'b0;
		else
			fault_pulse <= i_bus_req.request && unmapped && !fault_pulse;
	end

	assign o_bus_fault = fault_pulse;

	always_comb begin
		if (ram_hit)
			o_bus_rsp = i_ram_rsp;
		else if (ctrl_hit)
			o_bus_rsp = i_ctrl_rsp;
		else
			o_bus_rsp = '{rdata: '0, ready: fault_pulse};
	end

	// At most one responder per cycle
	assert property (@(posedge clock) disable iff (i_reset)
		$onehot0({i_ram_rsp.ready, i_ctrl_rsp.ready, fault_pulse}))
		else $error("address_decoder: ready from more than one slave");

endmodule

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter import soc_bus_pkg::*; (
	input  logic     clock,
	input  logic     i_reset,

	// Master ports
	input  bus_req_t i_instr_req,
	input  bus_req_t i_data_req,
	input  bus_req_t i_dma_req,
	output bus_rsp_t o_instr_rsp,
	output bus_rsp_t o_data_rsp,
	output bus_rsp_t o_dma_rsp,

	// Shared bus
	output bus_req_t o_bus_req,
	input  bus_rsp_t i_bus_rsp
);

	grant_t grant;

	//============================================================
	// Grant register
	//============================================================

	// Priority order is data, DMA, instruction.
	// The grant drops the cycle after ready, which leaves one idle
	// cycle on the shared bus between transactions
	always_ff @(posedge clock) begin
		if (i_reset) begin
			grant <= GRANT_NONE;
		end else if (grant == GRANT_NONE) begin
			if (i_data_req.request)
				grant <= GRANT_DATA;
			else if (i_dma_req.request)
				grant <= GRANT_DMA;
			else if (i_instr_req.request)
				grant <= GRANT_INSTR;
		end else if (i_bus_rsp.ready) begin
			grant <= GRANT_NONE;
		end
	end

	//============================================================
	// Request forwarding and response steering
	//============================================================

	always_comb begin
		case (grant)
			GRANT_DATA: o_bus_req = i_data_req;
			GRANT_DMA:  o_bus_req = i_dma_req;
			GRANT_INSTR: begin
				// Instruction fetches are always reads
				o_bus_req.request = i_instr_req.request;
				o_bus_req.rw      = 1'b0;
				o_bus_req.address = i_instr_req.address;
				o_bus_req.wdata   = '0;
			end
			default: o_bus_req = '0;
		endcase
	end

	always_comb begin
		o_instr_rsp.rdata = i_bus_rsp.rdata;
		o_data_rsp.rdata  = i_bus_rsp.rdata;
		o_dma_rsp.rdata   = i_bus_rsp.rdata;

		o_instr_rsp.ready = i_bus_rsp.ready && (grant == GRANT_INSTR);
		o_data_rsp.ready  = i_bus_rsp.ready && (grant == GRANT_DATA);
		o_dma_rsp.ready   = i_bus_rsp.ready && (grant == GRANT_DMA);
	end

	// Granted master holds its request and address until ready
	assert property (@(posedge clock) disable iff (i_reset)
		(o_bus_req.request && !i_bus_rsp.ready)
			|=> (o_bus_req.request && $stable(o_bus_req.address)))
		else $error("bus_arbiter: request dropped before ready");

endmodule

// ==== rtl/soc_map_pkg.sv ====
package soc_map_pkg;

	// Region code from address bits 31:28
	typedef logic [3:0] region_t;

	localparam region_t REGION_RAM   = 4'h1;
	localparam region_t REGION_LED   = 4'h4;
	localparam region_t REGION_TIMER = 4'ha;

	// Timer register index from address bits 3:2
	typedef logic [1:0] reg_index_t;

	localparam reg_index_t REG_COUNT   = 2'd0;
	localparam reg_index_t REG_COMPARE = 2'd1;
	localparam reg_index_t REG_CONTROL = 2'd2;

	// Red LED bank
	typedef logic [9:0] led_t;

endpackage

// ==== rtl/soc_bus_pkg.sv ====
package soc_bus_pkg;

	// Byte address and data word of the shared bus
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Master to slave, held stable until ready
	typedef struct packed {
		logic  request;
		logic  rw;
		addr_t address;
		data_t wdata;
	} bus_req_t;

	// Slave to master, ready is a single-cycle pulse
	typedef struct packed {
		data_t rdata;
		logic  ready;
	} bus_rsp_t;

	// Owner of the shared bus
	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_DATA,
		GRANT_DMA,
		GRANT_INSTR
	} grant_t;

endpackage
